//--- fpPkg.sv
`default_nettype none

package fpPkg;

	// ==============================
	// Widths with a meaning
	// ==============================

	// Processor bus address and data
	typedef logic [23:0] busAddr;
	typedef logic [7:0] busByte;

	// Register offset inside the device window
	typedef logic [3:0] regOffset;

	// IEEE single precision word and 16-bit signed integer
	typedef logic [31:0] fpWord;
	typedef logic signed [15:0] fixWord;

	// ==============================
	// Register map
	// ==============================

	// Device window, address bits 23..4 must match
	localparam busAddr accelBase = 24'hFEA200;

	// FAC1 bytes 0..3 and FAC2 bytes 4..7, little endian
	localparam regOffset fac1Offset = 4'd0;
	localparam regOffset fac2Offset = 4'd4;

	// Command on write, status on read
	localparam regOffset cmdOffset = 4'd15;

	// Status bit positions
	localparam int statusBusyBit = 7;
	localparam int statusOvfBit = 6;

	// Exponent bias of single precision
	localparam logic [7:0] fixBias = 8'd127;

	// ==============================
	// Commands and FSM states
	// ==============================

	typedef enum logic [7:0] {
		NEG = 8'd1,
		ABS = 8'd2,
		FIX2FLT = 8'd5,
		FLT2FIX = 8'd6,
		SWAP = 8'd17
	} fpCmd;

	typedef enum logic [1:0] {IDLE, NORM, DENORM, DONE} execState;

	// ==============================
	// Bundles
	// ==============================

	// One bus cycle as seen by the device, 34 bits
	typedef struct packed {
		logic vda;
		logic rw;
		busAddr ad;
		busByte data;
	} busReq;

	// Decoded byte write into the accumulators
	typedef struct packed {
		logic en;
		regOffset offset;
		busByte data;
	} regWrite;

	// Write-back from the execute unit
	typedef struct packed {
		logic valid;
		fpWord fac1;
		fpWord fac2;
		logic writeFac2;
		logic ovf;
	} execResult;

endpackage

`default_nettype wire

//--- fpBusDecode.sv
`default_nettype none

module fpBusDecode import fpPkg::*; (
	input logic clk,
	input logic rst,
	input busReq bus,
	input fpWord fac1,
	input fpWord fac2,
	input busByte status,
	output regWrite wr,
	output logic cmdStrobe,
	output fpCmd cmd,
	output busByte dataOut
);

	// Address decode
	logic hit;
	regOffset offset;

	// Qualified bus cycles
	logic wrCycle;
	logic rdCycle;

	// Read path
	fpWord rdWord;
	busByte rdByte;

	// ==============================
	// Address match
	// ==============================

	// Upper 20 address bits select the device
	assign hit = (bus.ad[23:4] == accelBase[23:4]);
	assign offset = bus.ad[3:0];

	// Valid data address with direction
	assign wrCycle = bus.vda && !bus.rw && hit;
	assign rdCycle = bus.vda && bus.rw && hit;

	// ==============================
	// Write strobes
	// ==============================

	// Byte write for the eight accumulator bytes
	// Offsets 8..15 never reach the accumulators
	always_comb begin
		wr.en = wrCycle && !offset[3];
		wr.offset = offset;
		wr.data = bus.data;
	end

	// Command register write
	assign cmdStrobe = wrCycle && (offset == cmdOffset);

	// Unknown codes pass through, execute rejects them
	assign cmd = fpCmd'(bus.data);

	// ==============================
	// Read mux
	// ==============================

	// Accumulator word picked by offset bit 2
	always_comb begin
		if (offset[3:2] == fac1Offset[3:2])
			rdWord = fac1;
		else
			rdWord = fac2;
	end

	// Byte lane within the word, status at 15, holes read zero
	always_comb begin
		if (offset == cmdOffset)
			rdByte = status;
		else if (!offset[3])
			rdByte = rdWord[{offset[1:0], 3'b000} +: 8];
		else
			rdByte = '0;
	end

	// One cycle of read latency
	// Held until the next read cycle
	always_ff @(posedge clk) begin
		if (rst)
			dataOut <= '0;
		else if (rdCycle)
			dataOut <= rdByte;
	end

endmodule

`default_nettype wire

//--- fpExecute.sv
`default_nettype none

module fpExecute import fpPkg::*; (
	input logic clk,
	input logic rst,
	input logic cmdStrobe,
	input fpCmd cmd,
	input fpWord fac1,
	input fpWord fac2,
	output logic busy,
	output busByte status,
	output execResult result
);

	// Exponent of a value whose top integer bit is bit 15
	localparam logic [7:0] fixTopExp = fixBias + 8'd15;

	// Control
	execState state;
	execState stateNext;
	logic knownCmd;
	logic accept;
	logic ovfSticky;

	// Conversion working set
	logic sign;
	logic [7:0] expCnt;
	logic [15:0] mant;

	// Result hold registers
	fpWord resFac1;
	fpWord resFac2;
	logic resWriteFac2;
	logic resOvf;

	// Operand views
	logic [15:0] fixIn;
	logic [15:0] fixMag;
	logic [7:0] fltExp;

	// Integer output of FLT2FIX
	fixWord fixOut;
	logic fixSat;

	// ==============================
	// Operand decode
	// ==============================

	assign fixIn = fac1[15:0];
	// Magnitude, -32768 gives 16'h8000 which still fits
	assign fixMag = fixIn[15] ? (~fixIn + 16'd1) : fixIn;
	assign fltExp = fac1[30:23];

	// Only the five supported codes start the unit
	assign knownCmd = cmd inside {NEG, ABS, FIX2FLT, FLT2FIX, SWAP};
	assign accept = (state == IDLE) && cmdStrobe && knownCmd;

	// Signed integer from magnitude, with range check
	// Negative side reaches 32768, positive only 32767
	always_comb begin
		fixSat = sign ? (mant > 16'h8000) : mant[15];
		if (fixSat)
			fixOut = sign ? fixWord'(16'h8000) : fixWord'(16'h7FFF);
		else if (sign)
			fixOut = fixWord'(~mant + 16'd1);
		else
			fixOut = fixWord'(mant);
	end

	// ==============================
	// FSM
	// ==============================

	always_comb begin
		stateNext = state;
		case (state)
			IDLE: begin
				if (accept) begin
					if (cmd == FIX2FLT && fixMag != 16'd0)
						stateNext = NORM;
					else if (cmd == FLT2FIX && fltExp >= fixBias && fltExp <= fixTopExp)
						stateNext = DENORM;
					else
						stateNext = DONE;
				end
			end
			// Until the leading one reaches bit 15
			NORM: if (mant[15]) stateNext = DONE;
			// Until the binary point sits below bit 0
			DENORM: if (expCnt == fixTopExp) stateNext = DONE;
			DONE: stateNext = IDLE;
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ovfSticky <= 1'b0;
		end else begin
			state <= stateNext;
			// Cleared by a new command, latched on completion
			if (accept)
				ovfSticky <= 1'b0;
			else if (state == DONE)
				ovfSticky <= resOvf;
		end
	end

	// ==============================
	// Datapath
	// ==============================

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (accept) begin
					resWriteFac2 <= (cmd == SWAP);
					resOvf <= 1'b0;
					case (cmd)
						NEG: resFac1 <= {~fac1[31], fac1[30:0]};
						ABS: resFac1 <= {1'b0, fac1[30:0]};
						SWAP: begin
							resFac1 <= fac2;
							resFac2 <= fac1;
						end
						FIX2FLT: begin
							// Zero input leaves +0.0 here
							sign <= fixIn[15];
							mant <= fixMag;
							expCnt <= fixTopExp;
							resFac1 <= '0;
						end
						FLT2FIX: begin
							// Hidden bit on top, low 8 fraction bits drop out
							sign <= fac1[31];
							mant <= {1'b1, fac1[22:8]};
							expCnt <= fltExp;
							// Too large, infinity and NaN saturate by sign
							if (fltExp > fixTopExp) begin
								resFac1 <= {16'h0000, fac1[31] ? 16'h8000 : 16'h7FFF};
								resOvf <= 1'b1;
							end else begin
								resFac1 <= '0;
							end
						end
						default: resFac1 <= fac1;
					endcase
				end
			end
			NORM: begin
				if (mant[15]) begin
					// Leading one becomes the hidden bit
					resFac1 <= {sign, expCnt, mant[14:0], 8'h00};
				end else begin
					mant <= {mant[14:0], 1'b0};
					expCnt <= expCnt - 8'd1;
				end
			end
			DENORM: begin
				if (expCnt == fixTopExp) begin
					resFac1 <= {16'h0000, fixOut};
					resOvf <= fixSat;
				end else begin
					// Truncation toward zero
					mant <= {1'b0, mant[15:1]};
					expCnt <= expCnt + 8'd1;
				end
			end
			default: begin
			end
		endcase
	end

	// ==============================
	// Outputs
	// ==============================

	assign busy = (state != IDLE);

	always_comb begin
		status = '0;
		status[statusBusyBit] = busy;
		status[statusOvfBit] = ovfSticky;
	end

	// Write-back presented for the single DONE cycle
	always_comb begin
		result.valid = (state == DONE);
		result.fac1 = resFac1;
		result.fac2 = resFac2;
		result.writeFac2 = resWriteFac2;
		result.ovf = resOvf;
	end

endmodule

`default_nettype wire

//--- fpAccumulators.sv
`default_nettype none

module fpAccumulators import fpPkg::*; (
	input logic clk,
	input logic rst,
	input regWrite wr,
	input logic busy,
	input execResult result,
	output fpWord fac1,
	output fpWord fac2
);

	// Bus write qualified by the busy lockout
	logic busWrEn;

	// Target word and byte lane of a bus write
	logic selFac1;
	logic [4:0] laneBase;

	// ==============================
	// Bus write decode
	// ==============================

	// Writes while a command runs are dropped
	assign busWrEn = wr.en && !busy;

	// Offset bit 2 picks the accumulator
	assign selFac1 = (wr.offset[3:2] == fac1Offset[3:2]);

	// Little endian, offset 0 is bits 7..0
	assign laneBase = {wr.offset[1:0], 3'b000};

	// ==============================
	// Storage
	// ==============================

	// Result write-back wins over the bus
	always_ff @(posedge clk) begin
		if (rst) begin
			fac1 <= '0;
			fac2 <= '0;
		end else if (result.valid) begin
			fac1 <= result.fac1;
			// Only SWAP touches FAC2
			if (result.writeFac2)
				fac2 <= result.fac2;
		end else if (busWrEn) begin
			if (selFac1)
				fac1[laneBase +: 8] <= wr.data;
			else
				fac2[laneBase +: 8] <= wr.data;
		end
	end

endmodule

`default_nettype wire

//--- fpAccel.sv
`default_nettype none

module fpAccel import fpPkg::*; (
	input logic clk,
	input logic rst,
	input busReq bus,
	output busByte dataOut
);

	// Decode to accumulators
	regWrite wr;

	// Decode to execute
	logic cmdStrobe;
	fpCmd cmd;

	// Execute outputs
	logic busy;
	busByte status;
	execResult result;

	// Accumulator contents
	fpWord fac1;
	fpWord fac2;

	// ==============================
	// Bus side
	// ==============================

	fpBusDecode fpBusDecode_i (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.fac1(fac1),
		.fac2(fac2),
		.status(status),
		.wr(wr),
		.cmdStrobe(cmdStrobe),
		.cmd(cmd),
		.dataOut(dataOut)
	);

	// ==============================
	// Command engine
	// ==============================

	fpExecute fpExecute_i (
		.clk(clk),
		.rst(rst),
		.cmdStrobe(cmdStrobe),
		.cmd(cmd),
		.fac1(fac1),
		.fac2(fac2),
		.busy(busy),
		.status(status),
		.result(result)
	);

	// FAC1 and FAC2 storage
	fpAccumulators fpAccumulators_i (
		.clk(clk),
		.rst(rst),
		.wr(wr),
		.busy(busy),
		.result(result),
		.fac1(fac1),
		.fac2(fac2)
	);

endmodule

`default_nettype wire

//--- fpAccel_properties.sv
`default_nettype none

module fpAccel_properties import fpPkg::*; (
	input logic clk,
	input logic rst,
	input logic busy,
	input busByte status,
	input execResult result
);

	timeunit 1ns;
	timeprecision 1ps;

	// ==============================
	// Busy and write-back rules
	// ==============================

	// Busy stays low on the cycle after every reset cycle
	assertResetIdle: assert property (@(posedge clk) rst |=> !busy)
		else $error("busy high after a reset cycle");

	// A newly accepted command clears the sticky overflow
	assertOvfCleared: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> !status[statusOvfBit])
		else $error("overflow flag survived a new command");

	// Busy ends exactly on the write-back cycle
	assertFallOnValid: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> $past(result.valid))
		else $error("busy fell without a result");

endmodule

bind fpExecute fpAccel_properties fpAccel_properties_i (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.status(status),
	.result(result)
);

`default_nettype wire

//--- fpAccel_tb.sv
`default_nettype none

module fpAccel_tb import fpPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// DUT side
	logic clk = 1'b0;
	logic rst;
	busReq bus;
	busByte dataOut;

	// Reference model of the accumulators and the sticky overflow
	fpWord mFac1;
	fpWord mFac2;
	logic mOvf;

	// Bookkeeping
	integer seed;
	int errorCount;
	int checkCount;
	fixWord corner[5];

	fpAccel fpAccel_i (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.dataOut(dataOut)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ==============================
	// Checks and reference model
	// ==============================

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
		end
	endtask

	// Exact IEEE encoding of a 16-bit integer
	function automatic fpWord floatOf(input fixWord v);
		int iv;
		int m;
		int top;
		int sh;
		iv = int'(v);
		if (iv == 0)
			return 32'h0;
		m = (iv < 0) ? -iv : iv;
		top = 0;
		// Highest set bit gives the unbiased exponent
		for (int b = 0; b < 17; b++)
			if (m[b])
				top = b;
		sh = m << (23 - top);
		return {v[15], 8'(127 + top), sh[22:0]};
	endfunction

	// Truncate toward zero, saturate out of range values
	task automatic convertToFix(input fpWord f, output fpWord res, output logic ovf);
		int e;
		int mag;
		int val;
		e = {24'd0, f[30:23]};
		ovf = 1'b0;
		if (e < 127) begin
			val = 0;
		end else if (e > 142) begin
			// Also covers infinity and NaN
			val = f[31] ? -32768 : 32767;
			ovf = 1'b1;
		end else begin
			mag = int'({8'd0, 1'b1, f[22:0]} >> (150 - e));
			val = f[31] ? -mag : mag;
			if (val > 32767) begin
				val = 32767;
				ovf = 1'b1;
			end else if (val < -32768) begin
				val = -32768;
				ovf = 1'b1;
			end
		end
		res = {16'h0000, val[15:0]};
	endtask

	task automatic applyModel(input fpCmd c);
		fpWord t;
		mOvf = 1'b0;
		case (c)
			NEG: mFac1[31] = ~mFac1[31];
			ABS: mFac1[31] = 1'b0;
			SWAP: begin
				t = mFac1;
				mFac1 = mFac2;
				mFac2 = t;
			end
			FIX2FLT: mFac1 = floatOf(fixWord'(mFac1[15:0]));
			FLT2FIX: convertToFix(mFac1, mFac1, mOvf);
			default: begin
			end
		endcase
	endtask

	function automatic busByte modelByte(input regOffset off);
		if (off[2])
			return mFac2[{off[1:0], 3'b000} +: 8];
		return mFac1[{off[1:0], 3'b000} +: 8];
	endfunction

	// ==============================
	// Bus tasks
	// ==============================

	task automatic busWrite(input regOffset offset, input busByte data);
		@(posedge clk);
		bus <= '{vda: 1'b1, rw: 1'b0, ad: {accelBase[23:4], offset}, data: data};
		@(posedge clk);
		bus <= '{vda: 1'b0, rw: 1'b1, ad: 24'h0, data: 8'h00};
	endtask

	// Data shows up one edge after the read cycle
	task automatic busRead(input regOffset offset, output busByte data);
		@(posedge clk);
		bus <= '{vda: 1'b1, rw: 1'b1, ad: {accelBase[23:4], offset}, data: 8'h00};
		@(posedge clk);
		bus <= '{vda: 1'b0, rw: 1'b1, ad: 24'h0, data: 8'h00};
		@(negedge clk);
		data = dataOut;
	endtask

	task automatic waitIdle(output busByte status);
		int polls;
		status = 8'h80;
		polls = 0;
		while (status[statusBusyBit] && polls < 40) begin
			busRead(cmdOffset, status);
			polls++;
		end
		if (status[statusBusyBit]) begin
			errorCount++;
			$display("waitIdle gave up after 40 status polls, busy never cleared");
		end
	endtask

	// Byte write that the model follows, only while idle
	task automatic writeByte(input regOffset offset, input busByte data);
		busWrite(offset, data);
		if (offset[2])
			mFac2[{offset[1:0], 3'b000} +: 8] = data;
		else
			mFac1[{offset[1:0], 3'b000} +: 8] = data;
	endtask

	task automatic loadWord(input regOffset base, input fpWord w);
		for (int j = 0; j < 4; j++)
			writeByte(regOffset'(base + j), w[8 * j +: 8]);
	endtask

	// Read all eight bytes back and compare both accumulators
	task automatic checkAcc();
		fpWord f1;
		fpWord f2;
		busByte b;
		for (int i = 0; i < 8; i++) begin
			busRead(regOffset'(i), b);
			if (i < 4)
				f1[8 * i +: 8] = b;
			else
				f2[8 * (i - 4) +: 8] = b;
		end
		checkValue("fac1", mFac1, f1);
		checkValue("fac2", mFac2, f2);
	endtask

	task automatic runCmd(input fpCmd c);
		busByte status;
		busWrite(cmdOffset, c);
		applyModel(c);
		waitIdle(status);
		checkValue("ovf", 32'(mOvf), 32'(status[statusOvfBit]));
		checkAcc();
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("%s finished with %0d errors", name, errorCount - startErrors);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		busByte b;
		fpCmd c;
		int k;
		int mag;
		int startErrors;
		fixWord v;
		seed = 32'hd3d18116;
		errorCount = 0;
		checkCount = 0;
		mFac1 = '0;
		mFac2 = '0;
		mOvf = 1'b0;
		corner = '{16'h0000, 16'h0001, 16'hFFFF, 16'h7FFF, 16'h8000};
		rst <= 1'b1;
		bus <= '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// Status after reset, then random byte traffic
		startErrors = errorCount;
		busRead(cmdOffset, b);
		checkValue("status", 32'd0, 32'(b));
		for (int i = 0; i < 50; i++) begin
			k = {$random(seed)} % 8;
			writeByte(regOffset'(k), 8'($random(seed)));
			busRead(regOffset'(k), b);
			checkValue("readback", 32'(modelByte(regOffset'(k))), 32'(b));
		end
		// Holes in the map
		for (int i = 8; i < 15; i++) begin
			busRead(regOffset'(i), b);
			checkValue("unmapped", 32'd0, 32'(b));
		end
		checkAcc();
		reportTest("register readback", startErrors);

		// Corner integers first
		// Upper FAC1 bits carry noise
		startErrors = errorCount;
		for (int i = 0; i < 105; i++) begin
			if (i < 5)
				v = corner[i];
			else
				v = fixWord'($random(seed));
			loadWord(fac1Offset, {16'($random(seed)), v});
			runCmd(FIX2FLT);
		end
		reportTest("FIX2FLT", startErrors);

		// Exponents 100..160 cover zero results, exact range and saturation
		startErrors = errorCount;
		for (int i = 0; i < 100; i++) begin
			k = 100 + ({$random(seed)} % 61);
			loadWord(fac1Offset, {1'($random(seed)), 8'(k), 23'($random(seed))});
			runCmd(FLT2FIX);
		end
		reportTest("FLT2FIX", startErrors);

		// Single cycle commands
		// Busy already low on the first poll
		startErrors = errorCount;
		for (int i = 0; i < 30; i++) begin
			loadWord(fac1Offset, 32'($random(seed)));
			loadWord(fac2Offset, 32'($random(seed)));
			k = {$random(seed)} % 3;
			c = (k == 0) ? SWAP : ((k == 1) ? NEG : ABS);
			busWrite(cmdOffset, c);
			busRead(cmdOffset, b);
			checkValue("busy", 32'd0, 32'(b[statusBusyBit]));
			applyModel(c);
			checkValue("ovf", 32'(mOvf), 32'(b[statusOvfBit]));
			checkAcc();
		end
		reportTest("SWAP NEG ABS", startErrors);

		// Small magnitudes keep FIX2FLT busy for a long normalization
		startErrors = errorCount;
		for (int i = 0; i < 10; i++) begin
			mag = 1 + ({$random(seed)} % 7);
			v = fixWord'(($random(seed) & 1) ? -mag : mag);
			loadWord(fac1Offset, {16'h0000, v});
			loadWord(fac2Offset, 32'($random(seed)));
			busWrite(cmdOffset, FIX2FLT);
			applyModel(FIX2FLT);
			// FAC2 byte write and SWAP both land while busy and must vanish
			busWrite(fac2Offset + 4'd3, 8'($random(seed)));
			busWrite(cmdOffset, SWAP);
			waitIdle(b);
			checkValue("ovf", 32'(mOvf), 32'(b[statusOvfBit]));
			checkAcc();
		end
		reportTest("busy lockout", startErrors);

		$display("checks=%0d errors=%0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
fpPkg.sv
fpBusDecode.sv
fpExecute.sv
fpAccumulators.sv
fpAccel.sv
fpAccel_properties.sv
fpAccel_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module fpAccel_tb -f compile.f \
	&& ./obj_dir/VfpAccel_tb 2>&1 | tee sim.log \
	&& ! grep -q "TEST FAILED" sim.log \
	&& grep -q "TEST OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
